// File: user_soc_pkg.sv
package user_soc_pkg;

    //--------------------------------------------------
    // Bus and pad widths
    //--------------------------------------------------
    localparam int WB_WIDTH      = 32;  // Address and data
    localparam int WB_SEL_WIDTH  = 4;   // Byte enables
    localparam int IO_WIDTH      = 32;
    localparam int IRQ_WIDTH     = 2;

    //--------------------------------------------------
    // Address map
    //--------------------------------------------------
    localparam int SLV_SEL_LSB   = 8;   // Slave select at adr[9:8]
    localparam int SLV_SEL_WIDTH = 2;
    localparam int REG_IDX_WIDTH = 6;   // Word index at adr[7:2]

    // Global block offsets
    localparam logic [REG_IDX_WIDTH-1:0] GLBL_CHIP_ID_IDX  = 6'd0;  // 0x00
    localparam logic [REG_IDX_WIDTH-1:0] GLBL_SCRATCH_IDX  = 6'd1;  // 0x04
    localparam logic [REG_IDX_WIDTH-1:0] GLBL_SOFT_IRQ_IDX = 6'd2;  // 0x08

    // Pinmux block offsets
    localparam logic [REG_IDX_WIDTH-1:0] GPIO_OUT_IDX    = 6'd0;    // 0x00
    localparam logic [REG_IDX_WIDTH-1:0] GPIO_OEB_IDX    = 6'd1;    // 0x04
    localparam logic [REG_IDX_WIDTH-1:0] GPIO_IN_IDX     = 6'd2;    // 0x08
    localparam logic [REG_IDX_WIDTH-1:0] GPIO_IRQ_EN_IDX = 6'd3;    // 0x0C

    // Constants and reset values
    localparam logic [WB_WIDTH-1:0] CHIP_ID      = 32'h5553_0C01;
    localparam logic [WB_WIDTH-1:0] ERR_DATA     = 32'hDEAD_C0DE;  // Unmapped read data
    localparam logic [IO_WIDTH-1:0] GPIO_OUT_RST = '0;
    localparam logic [IO_WIDTH-1:0] GPIO_OEB_RST = '1;             // All pads inputs

    typedef enum logic [SLV_SEL_WIDTH-1:0] {
        SLV_GLBL   = 2'd0,
        SLV_PINMUX = 2'd1,
        SLV_NONE   = 2'd2
    } slv_sel_e;

    typedef enum logic [1:0] {
        HOST_IDLE,
        HOST_REQ,
        HOST_RESP
    } host_state_e;

endpackage : user_soc_pkg

// File: wb_host.sv
module wb_host
    import user_soc_pkg::*;
(
    input  logic                      wb_clk_i,
    input  logic                      reset_i,

    // Master side
    input  logic                      wbs_cyc_i,
    input  logic                      wbs_stb_i,
    input  logic                      wbs_we_i,
    input  logic [WB_WIDTH-1:0]       wbs_adr_i,
    input  logic [WB_WIDTH-1:0]       wbs_dat_i,
    input  logic [WB_SEL_WIDTH-1:0]   wbs_sel_i,
    output logic [WB_WIDTH-1:0]       wbs_dat_o,
    output logic                      wbs_ack_o,

    // Interconnect side
    input  logic                      rsp_ack_i,
    input  logic [WB_WIDTH-1:0]       rsp_dat_i,
    output logic                      req_stb_o,
    output logic                      req_we_o,
    output logic [WB_WIDTH-1:0]       req_adr_o,
    output logic [WB_WIDTH-1:0]       req_dat_o,
    output logic [WB_SEL_WIDTH-1:0]   req_sel_o
);

    host_state_e state_q;

    // The ack cycle blocks a restart while the master still holds stb
    logic        new_req;
    assign new_req = wbs_cyc_i && wbs_stb_i && !wbs_ack_o;

    //--------------------------------------------------
    // Control FSM
    //--------------------------------------------------
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            state_q   <= HOST_IDLE;
            req_stb_o <= 1'b0;
            wbs_ack_o <= 1'b0;
        end else begin
            req_stb_o <= 1'b0;  // Single cycle strobe
            wbs_ack_o <= 1'b0;  // Single cycle ack
            case (state_q)
                HOST_IDLE: begin
                    if (new_req) state_q <= HOST_REQ;
                end
                HOST_REQ: begin
                    req_stb_o <= 1'b1;
                    state_q   <= HOST_RESP;
                end
                HOST_RESP: begin
                    if (rsp_ack_i) begin
                        wbs_ack_o <= 1'b1;
                        state_q   <= HOST_IDLE;
                    end
                end
                default: state_q <= HOST_IDLE;
            endcase
        end
    end

    //--------------------------------------------------
    // Request capture and response data
    //--------------------------------------------------
    always_ff @(posedge wb_clk_i) begin
        if (state_q == HOST_IDLE && new_req) begin
            req_we_o  <= wbs_we_i;
            req_adr_o <= wbs_adr_i;
            req_dat_o <= wbs_dat_i;
            req_sel_o <= wbs_sel_i;
        end
        if (state_q == HOST_RESP && rsp_ack_i)
            wbs_dat_o <= rsp_dat_i;  // Held until the next response
    end

endmodule : wb_host

// File: wb_intercon.sv
module wb_intercon
    import user_soc_pkg::*;
(
    input  logic                      wb_clk_i,
    input  logic                      reset_i,

    // From host
    input  logic                      req_stb_i,
    input  logic                      req_we_i,
    input  logic [WB_WIDTH-1:0]       req_adr_i,
    input  logic [WB_WIDTH-1:0]       req_dat_i,
    input  logic [WB_SEL_WIDTH-1:0]   req_sel_i,
    output logic                      rsp_ack_o,
    output logic [WB_WIDTH-1:0]       rsp_dat_o,

    // Slave responses
    input  logic                      glbl_ack_i,
    input  logic [WB_WIDTH-1:0]       glbl_rdata_i,
    input  logic                      pinmux_ack_i,
    input  logic [WB_WIDTH-1:0]       pinmux_rdata_i,

    // Shared register bus
    output logic                      glbl_cs_o,
    output logic                      pinmux_cs_o,
    output logic                      reg_wr_o,
    output logic [REG_IDX_WIDTH-1:0]  reg_idx_o,
    output logic [WB_WIDTH-1:0]       reg_wdata_o,
    output logic [WB_SEL_WIDTH-1:0]   reg_be_o
);

    slv_sel_e slv_sel;
    logic     none_ack_q;  // Local ack for unmapped slaves

    //--------------------------------------------------
    // Address decode
    //--------------------------------------------------
    always_comb begin
        case (req_adr_i[SLV_SEL_LSB +: SLV_SEL_WIDTH])
            2'd0:    slv_sel = SLV_GLBL;
            2'd1:    slv_sel = SLV_PINMUX;
            default: slv_sel = SLV_NONE;  // Codes 2 and 3
        endcase
    end

    assign glbl_cs_o   = req_stb_i && (slv_sel == SLV_GLBL);
    assign pinmux_cs_o = req_stb_i && (slv_sel == SLV_PINMUX);

    assign reg_wr_o    = req_we_i;
    assign reg_idx_o   = req_adr_i[SLV_SEL_LSB-1:2];
    assign reg_wdata_o = req_dat_i;
    assign reg_be_o    = req_sel_i;

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) none_ack_q <= 1'b0;
        else         none_ack_q <= req_stb_i && (slv_sel == SLV_NONE);
    end

    //--------------------------------------------------
    // Response mux
    //--------------------------------------------------
    assign rsp_ack_o = glbl_ack_i | pinmux_ack_i | none_ack_q;

    always_comb begin
        if (glbl_ack_i)        rsp_dat_o = glbl_rdata_i;
        else if (pinmux_ack_i) rsp_dat_o = pinmux_rdata_i;
        else                   rsp_dat_o = ERR_DATA;
    end

endmodule : wb_intercon

// File: glbl_regs.sv
module glbl_regs
    import user_soc_pkg::*;
(
    input  logic                      wb_clk_i,
    input  logic                      reset_i,

    input  logic                      reg_cs_i,
    input  logic                      reg_wr_i,
    input  logic [REG_IDX_WIDTH-1:0]  reg_idx_i,
    input  logic [WB_WIDTH-1:0]       reg_wdata_i,
    input  logic [WB_SEL_WIDTH-1:0]   reg_be_i,
    output logic [WB_WIDTH-1:0]       reg_rdata_o,
    output logic                      reg_ack_o,

    output logic                      soft_irq_o
);

    logic [WB_WIDTH-1:0] scratch_q;
    logic                wr_en;

    assign wr_en = reg_cs_i && reg_wr_i;

    // Register writes, chip ID ignores them
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            scratch_q  <= '0;
            soft_irq_o <= 1'b0;
        end else if (wr_en) begin
            if (reg_idx_i == GLBL_SCRATCH_IDX) begin
                for (int b = 0; b < WB_SEL_WIDTH; b++) begin
                    if (reg_be_i[b]) scratch_q[8*b +: 8] <= reg_wdata_i[8*b +: 8];
                end
            end
            if (reg_idx_i == GLBL_SOFT_IRQ_IDX && reg_be_i[0])
                soft_irq_o <= reg_wdata_i[0];
        end
    end

    // Read data and ack, one cycle after cs
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) reg_ack_o <= 1'b0;
        else         reg_ack_o <= reg_cs_i;
    end

    always_ff @(posedge wb_clk_i) begin
        if (reg_cs_i) begin
            case (reg_idx_i)
                GLBL_CHIP_ID_IDX:  reg_rdata_o <= CHIP_ID;
                GLBL_SCRATCH_IDX:  reg_rdata_o <= scratch_q;
                GLBL_SOFT_IRQ_IDX: reg_rdata_o <= {{(WB_WIDTH-1){1'b0}}, soft_irq_o};
                default:           reg_rdata_o <= '0;  // Undefined offset
            endcase
        end
    end

endmodule : glbl_regs

// File: pinmux_regs.sv
module pinmux_regs
    import user_soc_pkg::*;
(
    input  logic                      wb_clk_i,
    input  logic                      reset_i,

    input  logic                      reg_cs_i,
    input  logic                      reg_wr_i,
    input  logic [REG_IDX_WIDTH-1:0]  reg_idx_i,
    input  logic [WB_WIDTH-1:0]       reg_wdata_i,
    input  logic [WB_SEL_WIDTH-1:0]   reg_be_i,
    output logic [WB_WIDTH-1:0]       reg_rdata_o,
    output logic                      reg_ack_o,

    // Pads
    input  logic [IO_WIDTH-1:0]       io_in_i,
    output logic [IO_WIDTH-1:0]       io_out_o,
    output logic [IO_WIDTH-1:0]       io_oeb_o,  // Low drives the pad

    output logic                      gpio_irq_o
);

    logic [IO_WIDTH-1:0] io_in_meta_q;
    logic [IO_WIDTH-1:0] io_in_sync_q;
    logic [IO_WIDTH-1:0] irq_en_q;
    logic                wr_en;

    assign wr_en = reg_cs_i && reg_wr_i;

    //--------------------------------------------------
    // Input synchroniser and interrupt
    //--------------------------------------------------
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            io_in_meta_q <= '0;
            io_in_sync_q <= '0;
        end else begin
            io_in_meta_q <= io_in_i;
            io_in_sync_q <= io_in_meta_q;
        end
    end

    assign gpio_irq_o = |(io_in_sync_q & irq_en_q);

    //--------------------------------------------------
    // Control registers
    //--------------------------------------------------
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            io_out_o <= GPIO_OUT_RST;
            io_oeb_o <= GPIO_OEB_RST;
            irq_en_q <= '0;
        end else if (wr_en) begin
            for (int b = 0; b < WB_SEL_WIDTH; b++) begin
                if (reg_be_i[b]) begin
                    case (reg_idx_i)
                        GPIO_OUT_IDX:    io_out_o[8*b +: 8] <= reg_wdata_i[8*b +: 8];
                        GPIO_OEB_IDX:    io_oeb_o[8*b +: 8] <= reg_wdata_i[8*b +: 8];
                        GPIO_IRQ_EN_IDX: irq_en_q[8*b +: 8] <= reg_wdata_i[8*b +: 8];
                        default: ;  // GPIO_IN is read only
                    endcase
                end
            end
        end
    end

    // Ack follows cs by one cycle
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) reg_ack_o <= 1'b0;
        else         reg_ack_o <= reg_cs_i;
    end

    always_ff @(posedge wb_clk_i) begin
        if (reg_cs_i) begin
            case (reg_idx_i)
                GPIO_OUT_IDX:    reg_rdata_o <= io_out_o;
                GPIO_OEB_IDX:    reg_rdata_o <= io_oeb_o;
                GPIO_IN_IDX:     reg_rdata_o <= io_in_sync_q;
                GPIO_IRQ_EN_IDX: reg_rdata_o <= irq_en_q;
                default:         reg_rdata_o <= '0;
            endcase
        end
    end

endmodule : pinmux_regs

// File: user_project_wrapper.sv
module user_project_wrapper
    import user_soc_pkg::*;
(
    input  logic                      wb_clk_i,
    input  logic                      reset_i,

    // Wishbone slave port
    input  logic                      wbs_cyc_i,
    input  logic                      wbs_stb_i,
    input  logic                      wbs_we_i,
    input  logic [WB_WIDTH-1:0]       wbs_adr_i,
    input  logic [WB_WIDTH-1:0]       wbs_dat_i,
    input  logic [WB_SEL_WIDTH-1:0]   wbs_sel_i,
    output logic [WB_WIDTH-1:0]       wbs_dat_o,
    output logic                      wbs_ack_o,

    // IO pads and interrupts
    input  logic [IO_WIDTH-1:0]       io_in_i,
    output logic [IO_WIDTH-1:0]       io_out_o,
    output logic [IO_WIDTH-1:0]       io_oeb_o,
    output logic [IRQ_WIDTH-1:0]      user_irq_o
);

    //--------------------------------------------------
    // Host to interconnect
    //--------------------------------------------------
    logic                      req_stb, req_we, rsp_ack;
    logic [WB_WIDTH-1:0]       req_adr, req_dat, rsp_dat;
    logic [WB_SEL_WIDTH-1:0]   req_sel;

    // Register bus, shared by both slaves
    logic                      glbl_cs, pinmux_cs, reg_wr;
    logic [REG_IDX_WIDTH-1:0]  reg_idx;
    logic [WB_WIDTH-1:0]       reg_wdata, glbl_rdata, pinmux_rdata;
    logic [WB_SEL_WIDTH-1:0]   reg_be;
    logic                      glbl_ack, pinmux_ack;
    logic                      soft_irq, gpio_irq;

    wb_host u_wb_host (
        .wb_clk_i (wb_clk_i),  .reset_i  (reset_i),
        .wbs_cyc_i(wbs_cyc_i), .wbs_stb_i(wbs_stb_i), .wbs_we_i (wbs_we_i),
        .wbs_adr_i(wbs_adr_i), .wbs_dat_i(wbs_dat_i), .wbs_sel_i(wbs_sel_i),
        .wbs_dat_o(wbs_dat_o), .wbs_ack_o(wbs_ack_o),
        .rsp_ack_i(rsp_ack),   .rsp_dat_i(rsp_dat),
        .req_stb_o(req_stb),   .req_we_o (req_we),    .req_adr_o(req_adr),
        .req_dat_o(req_dat),   .req_sel_o(req_sel)
    );

    wb_intercon u_intercon (
        .wb_clk_i   (wb_clk_i),   .reset_i       (reset_i),
        .req_stb_i  (req_stb),    .req_we_i      (req_we),     .req_adr_i(req_adr),
        .req_dat_i  (req_dat),    .req_sel_i     (req_sel),
        .rsp_ack_o  (rsp_ack),    .rsp_dat_o     (rsp_dat),
        .glbl_ack_i (glbl_ack),   .glbl_rdata_i  (glbl_rdata),
        .pinmux_ack_i(pinmux_ack), .pinmux_rdata_i(pinmux_rdata),
        .glbl_cs_o  (glbl_cs),    .pinmux_cs_o   (pinmux_cs),  .reg_wr_o (reg_wr),
        .reg_idx_o  (reg_idx),    .reg_wdata_o   (reg_wdata),  .reg_be_o (reg_be)
    );

    glbl_regs u_glbl (
        .wb_clk_i   (wb_clk_i),  .reset_i  (reset_i),
        .reg_cs_i   (glbl_cs),   .reg_wr_i (reg_wr),   .reg_idx_i(reg_idx),
        .reg_wdata_i(reg_wdata), .reg_be_i (reg_be),
        .reg_rdata_o(glbl_rdata), .reg_ack_o(glbl_ack), .soft_irq_o(soft_irq)
    );

    pinmux_regs u_pinmux (
        .wb_clk_i   (wb_clk_i),   .reset_i  (reset_i),
        .reg_cs_i   (pinmux_cs),  .reg_wr_i (reg_wr),     .reg_idx_i(reg_idx),
        .reg_wdata_i(reg_wdata),  .reg_be_i (reg_be),
        .reg_rdata_o(pinmux_rdata), .reg_ack_o(pinmux_ack),
        .io_in_i    (io_in_i),    .io_out_o (io_out_o),   .io_oeb_o (io_oeb_o),
        .gpio_irq_o (gpio_irq)
    );

    assign user_irq_o = {soft_irq, gpio_irq};  // Bit 0 GPIO, bit 1 software

endmodule : user_project_wrapper

// File: tb_user_project_wrapper.sv
module tb_user_project_wrapper
    import user_soc_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    logic                    wb_clk_i;
    logic                    reset_i;
    logic                    wbs_cyc_i;
    logic                    wbs_stb_i;
    logic                    wbs_we_i;
    logic [WB_WIDTH-1:0]     wbs_adr_i;
    logic [WB_WIDTH-1:0]     wbs_dat_i;
    logic [WB_SEL_WIDTH-1:0] wbs_sel_i;
    logic [WB_WIDTH-1:0]     wbs_dat_o;
    logic                    wbs_ack_o;
    logic [IO_WIDTH-1:0]     io_in_i;
    logic [IO_WIDTH-1:0]     io_out_o;
    logic [IO_WIDTH-1:0]     io_oeb_o;
    logic [IRQ_WIDTH-1:0]    user_irq_o;

    // Shadow copy of the registers
    logic [31:0] scratch_sh, gpio_out_sh, gpio_oeb_sh, irq_en_sh, io_in_sh;
    logic        soft_irq_sh;
    logic [31:0] exp_rdata;
    logic        read_pending;
    logic [31:0] lfsr_q;

    user_project_wrapper DUT (
        .wb_clk_i (wb_clk_i),  .reset_i  (reset_i),
        .wbs_cyc_i(wbs_cyc_i), .wbs_stb_i(wbs_stb_i), .wbs_we_i (wbs_we_i),
        .wbs_adr_i(wbs_adr_i), .wbs_dat_i(wbs_dat_i), .wbs_sel_i(wbs_sel_i),
        .wbs_dat_o(wbs_dat_o), .wbs_ack_o(wbs_ack_o),
        .io_in_i  (io_in_i),   .io_out_o (io_out_o),  .io_oeb_o (io_oeb_o),
        .user_irq_o(user_irq_o)
    );

    initial begin
        wb_clk_i = 1'b0;
        forever #5 wb_clk_i = ~wb_clk_i;
    end

    //--------------------------------------------------
    // Reference model
    //--------------------------------------------------
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
            r = {r[30:0], lfsr_q[0]};  // One step per bit
        end
        return r;
    endfunction

    function automatic logic [31:0] reg_addr(input logic [1:0] slv, input logic [5:0] idx);
        return {20'h30000, 2'b00, slv, idx, 2'b00};
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_v, new_v,
                                                input logic [3:0] be);
        logic [31:0] r;
        r = old_v;
        for (int b = 0; b < 4; b++)
            if (be[b]) r[8*b +: 8] = new_v[8*b +: 8];
        return r;
    endfunction

    function automatic void update_shadow(input logic [31:0] adr, dat, input logic [3:0] be);
        if (adr[9:8] == SLV_GLBL) begin
            if (adr[7:2] == GLBL_SCRATCH_IDX) scratch_sh = merge_bytes(scratch_sh, dat, be);
            if (adr[7:2] == GLBL_SOFT_IRQ_IDX && be[0]) soft_irq_sh = dat[0];
        end else if (adr[9:8] == SLV_PINMUX) begin
            case (adr[7:2])
                GPIO_OUT_IDX:    gpio_out_sh = merge_bytes(gpio_out_sh, dat, be);
                GPIO_OEB_IDX:    gpio_oeb_sh = merge_bytes(gpio_oeb_sh, dat, be);
                GPIO_IRQ_EN_IDX: irq_en_sh   = merge_bytes(irq_en_sh, dat, be);
                default: ;  // Input register ignores writes
            endcase
        end
    endfunction

    function automatic logic [31:0] ref_read(input logic [31:0] adr);
        if (adr[9:8] == SLV_GLBL) begin
            case (adr[7:2])
                GLBL_CHIP_ID_IDX:  return CHIP_ID;
                GLBL_SCRATCH_IDX:  return scratch_sh;
                GLBL_SOFT_IRQ_IDX: return {31'b0, soft_irq_sh};
                default:           return '0;
            endcase
        end else if (adr[9:8] == SLV_PINMUX) begin
            case (adr[7:2])
                GPIO_OUT_IDX:    return gpio_out_sh;
                GPIO_OEB_IDX:    return gpio_oeb_sh;
                GPIO_IN_IDX:     return io_in_sh;
                GPIO_IRQ_EN_IDX: return irq_en_sh;
                default:         return '0;
            endcase
        end
        return ERR_DATA;  // Select codes 2 and 3
    endfunction

    task automatic check_value(input string name, input logic [31:0] got, exp);
        assert (got === exp)
        else begin
            $display("Mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    //--------------------------------------------------
    // Bus tasks
    //--------------------------------------------------
    task automatic wb_access(input logic we, input logic [31:0] adr, dat,
                             input logic [3:0] be);
        int lat;
        @(posedge wb_clk_i);
        wbs_cyc_i <= 1'b1;
        wbs_stb_i <= 1'b1;
        wbs_we_i  <= we;
        wbs_adr_i <= adr;
        wbs_dat_i <= dat;
        wbs_sel_i <= be;
        @(posedge wb_clk_i);  // Request sampled in idle
        lat = 0;
        @(negedge wb_clk_i);
        while (!wbs_ack_o) begin
            if (lat == 20) begin
                $display("Timeout at %0d ns: no ack for the access to address %h", $time, adr);
                $display("TB FAILED");
                $fatal(1);
            end
            lat++;
            @(negedge wb_clk_i);
        end
        check_value("wbs_ack_o latency", lat, 3);
        @(posedge wb_clk_i);
        wbs_cyc_i <= 1'b0;
        wbs_stb_i <= 1'b0;
        wbs_we_i  <= 1'b0;
    endtask

    task automatic wb_write(input logic [31:0] adr, dat, input logic [3:0] be);
        update_shadow(adr, dat, be);
        wb_access(1'b1, adr, dat, be);
    endtask

    task automatic wb_read(input logic [31:0] adr);
        exp_rdata    = ref_read(adr);
        read_pending = 1'b1;
        wb_access(1'b0, adr, '0, 4'hF);
    endtask

    // Read data compare on the ack cycle
    always @(negedge wb_clk_i) begin
        if (wbs_ack_o === 1'b1 && read_pending) begin
            check_value("wbs_dat_o", wbs_dat_o, exp_rdata);
            read_pending = 1'b0;
        end
    end

    //--------------------------------------------------
    // Test sequence
    //--------------------------------------------------
    initial begin : main_seq
        logic [31:0] d;
        logic [31:0] m;
        logic [3:0]  be;
        lfsr_q       = 32'd46;
        scratch_sh   = '0;
        soft_irq_sh  = 1'b0;
        gpio_out_sh  = '0;
        gpio_oeb_sh  = '1;
        irq_en_sh    = '0;
        io_in_sh     = '0;
        read_pending = 1'b0;
        reset_i   = 1'b1;
        wbs_cyc_i = 1'b0;
        wbs_stb_i = 1'b0;
        wbs_we_i  = 1'b0;
        wbs_adr_i = '0;
        wbs_dat_i = '0;
        wbs_sel_i = '0;
        io_in_i   = '0;
        repeat (2) @(posedge wb_clk_i);
        reset_i <= 1'b0;
        @(posedge wb_clk_i);

        check_value("wbs_ack_o", wbs_ack_o, 0);
        check_value("io_oeb_o", io_oeb_o, '1);
        check_value("io_out_o", io_out_o, '0);
        check_value("user_irq_o", user_irq_o, '0);
        wb_read(reg_addr(SLV_GLBL, GLBL_CHIP_ID_IDX));

        for (int i = 0; i < 8; i++) begin
            d  = rand_bits(32);
            be = 4'(rand_bits(4));
            wb_write(reg_addr(SLV_GLBL, GLBL_SCRATCH_IDX), d, be);
            wb_read(reg_addr(SLV_GLBL, GLBL_SCRATCH_IDX));
        end
        d = rand_bits(32);
        wb_write(reg_addr(SLV_GLBL, GLBL_CHIP_ID_IDX), d, 4'hF);  // Read only
        wb_read(reg_addr(SLV_GLBL, GLBL_CHIP_ID_IDX));

        // GPIO outputs reach the pads
        for (int i = 0; i < 6; i++) begin
            d  = rand_bits(32);
            be = 4'(rand_bits(4));
            wb_write(reg_addr(SLV_PINMUX, GPIO_OUT_IDX), d, be);
            d  = rand_bits(32);
            be = 4'(rand_bits(4));
            wb_write(reg_addr(SLV_PINMUX, GPIO_OEB_IDX), d, be);
            check_value("io_out_o", io_out_o, gpio_out_sh);
            check_value("io_oeb_o", io_oeb_o, gpio_oeb_sh);
            wb_read(reg_addr(SLV_PINMUX, GPIO_OUT_IDX));
            wb_read(reg_addr(SLV_PINMUX, GPIO_OEB_IDX));
        end

        for (int i = 0; i < 6; i++) begin
            d = rand_bits(32);
            m = (i == 5) ? ~d : rand_bits(32);  // Last pass masks every high input
            @(posedge wb_clk_i);
            io_in_i <= d;
            io_in_sh = d;
            for (int w = 0; w < 5; w++)
                @(posedge wb_clk_i);
            wb_read(reg_addr(SLV_PINMUX, GPIO_IN_IDX));
            wb_write(reg_addr(SLV_PINMUX, GPIO_IRQ_EN_IDX), m, 4'hF);
            check_value("user_irq_o[0]", user_irq_o[0], |(io_in_sh & irq_en_sh));
            wb_read(reg_addr(SLV_PINMUX, GPIO_IRQ_EN_IDX));
        end
        d = rand_bits(32);
        wb_write(reg_addr(SLV_PINMUX, GPIO_IN_IDX), d, 4'hF);
        wb_read(reg_addr(SLV_PINMUX, GPIO_IN_IDX));

        // Software interrupt
        wb_write(reg_addr(SLV_GLBL, GLBL_SOFT_IRQ_IDX), 32'h1, 4'h1);
        check_value("user_irq_o[1]", user_irq_o[1], 1);
        wb_read(reg_addr(SLV_GLBL, GLBL_SOFT_IRQ_IDX));
        wb_write(reg_addr(SLV_GLBL, GLBL_SOFT_IRQ_IDX), 32'h0, 4'h1);
        check_value("user_irq_o[1]", user_irq_o[1], 0);
        wb_read(reg_addr(SLV_GLBL, GLBL_SOFT_IRQ_IDX));

        // Unmapped slaves and undefined offsets
        wb_read(reg_addr(2'd2, GLBL_CHIP_ID_IDX));
        wb_read(reg_addr(2'd3, GLBL_SCRATCH_IDX));
        d = rand_bits(32);
        wb_write(reg_addr(2'd2, GLBL_SCRATCH_IDX), d, 4'hF);
        d = rand_bits(32);
        wb_write(reg_addr(2'd3, GPIO_OUT_IDX), d, 4'hF);
        check_value("io_out_o", io_out_o, gpio_out_sh);
        wb_read(reg_addr(SLV_GLBL, GLBL_SCRATCH_IDX));
        wb_read(reg_addr(SLV_PINMUX, GPIO_OUT_IDX));
        wb_read(reg_addr(SLV_GLBL, 6'd3));
        wb_read(reg_addr(SLV_GLBL, 6'd63));
        wb_read(reg_addr(SLV_PINMUX, 6'd4));
        wb_read(reg_addr(SLV_PINMUX, 6'd40));

        @(posedge wb_clk_i);
        $display("TB PASSED");
        $finish;
    end

endmodule : tb_user_project_wrapper

// File: user_soc.f
user_soc_pkg.sv
wb_host.sv
wb_intercon.sv
glbl_regs.sv
pinmux_regs.sv
user_project_wrapper.sv
tb_user_project_wrapper.sv
